//--- extWordDecoder.sv
// Extension-word decoder for the fetch sequencer.
// Next state for displacement, indexed, absolute and memory-indirect
// fetches. Keeps the outer-displacement flags of the full-format word
// for use after the base displacement has been read.
`timescale 1ns/1ps
`default_nettype none

module extWordDecoder (
    input  wire                         CLK,
    input  wire                         reset,
    input  wire fetchPkg::fetchStateT   fetchState,
    input  wire fetchPkg::opClassT      opClass,
    input  wire fetchPkg::extWordT      extWord,
    input  wire                         ewAck,
    input  wire                         memAdrRdy,
    input  wire                         arInUse,
    input  wire                         drInUse,
    output fetchPkg::fetchStateT        extNext,
    output logic                        extOwns
);

    import fetchPkg::*;

    dispSizeT   odSize;
    logic       isFull;
    logic       odLong;
    logic       odWord;
    logic       memInd;
    logic       odLongQ;    // Captured at the acknowledged extension word.
    logic       odWordQ;
    logic       memIndQ;
    logic       addrGate;
    fetchStateT classTarget;

    assign isFull = extWord.brief.fullFormat;
    assign odSize = dispSizeT'(extWord.full.idxIndSel[1:0]);
    assign odLong = isFull && (odSize == SIZE_LONG);
    assign odWord = isFull && (odSize == SIZE_WORD);
    assign memInd = isFull && (odSize != SIZE_RESERVED); // Any memory indirection.

    // A data index register in a brief word must be free as well.
    assign addrGate = !arInUse && !(!isFull && !extWord.brief.idxIsAddr && drInUse);

    always_comb begin
        case (opClass)
            OP_ALU_EA, OP_ALU_ADDR: classTarget = CALC_AEFF;
            OP_LOAD_ADR:            classTarget = SWITCH_STATE;
            default:                classTarget = INIT_EXEC_WB;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            odLongQ <= 1'b0;
            odWordQ <= 1'b0;
            memIndQ <= 1'b0;
        end else if (fetchState == FETCH_EXWORD_1 && ewAck) begin
            odLongQ <= odLong;
            odWordQ <= odWord;
            memIndQ <= memInd;
        end
    end

    always_comb begin
        extOwns = 1'b1;
        extNext = fetchState; // Hold unless a rule below fires.
        case (fetchState)
            FETCH_DISPL: begin
                if (ewAck && !arInUse) begin
                    extNext = classTarget;
                end
            end
            FETCH_EXWORD_1: begin
                if (ewAck && isFull) begin
                    case (extWord.full.bdSize)
                        SIZE_LONG:     extNext = FETCH_D_HI;
                        SIZE_WORD:     extNext = FETCH_D_LO;
                        SIZE_RESERVED: extNext = START_OP; // Illegal format.
                        default: begin
                            if (odLong) begin
                                extNext = FETCH_OD_HI;
                            end else if (odWord) begin
                                extNext = FETCH_OD_LO;
                            end else if (memInd) begin
                                extNext = FETCH_MEMADR;
                            end else if (addrGate) begin
                                extNext = classTarget;
                            end
                        end
                    endcase
                end else if (ewAck && addrGate) begin
                    extNext = classTarget; // Brief format.
                end
            end
            FETCH_D_HI: begin
                if (ewAck) begin
                    extNext = FETCH_D_LO;
                end
            end
            FETCH_D_LO: begin
                if (ewAck) begin
                    if (odLongQ) begin
                        extNext = FETCH_OD_HI;
                    end else if (odWordQ) begin
                        extNext = FETCH_OD_LO;
                    end else if (memIndQ) begin
                        extNext = FETCH_MEMADR;
                    end else if (!arInUse) begin
                        extNext = classTarget;
                    end
                end
            end
            FETCH_OD_HI: begin
                if (ewAck) begin
                    extNext = FETCH_OD_LO;
                end
            end
            FETCH_OD_LO: begin
                if (ewAck) begin
                    extNext = FETCH_MEMADR;
                end
            end
            FETCH_MEMADR: begin
                if (memAdrRdy && !arInUse) begin
                    extNext = classTarget;
                end
            end
            FETCH_ABS_HI: begin
                if (ewAck) begin
                    extNext = FETCH_ABS_LO;
                end
            end
            FETCH_ABS_LO: begin
                if (ewAck) begin
                    extNext = classTarget; // Address is complete, no hazard.
                end
            end
            default: begin
                extOwns = 1'b0;
                extNext = START_OP;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- fetchEntryDecoder.sv
// Entry decoder for the fetch sequencer.
// Picks the first fetch state from the address mode when an operation starts.
`timescale 1ns/1ps
`default_nettype none

module fetchEntryDecoder #(
    parameter int modeWidth = fetchPkg::ADR_MODE_WIDTH
) (
    input  wire fetchPkg::fetchStateT   fetchState,
    input  wire                         opStart,
    input  wire fetchPkg::opClassT      opClass,
    input  wire [modeWidth-1:0]         adrMode,
    input  wire [modeWidth-1:0]         adrReg,
    output fetchPkg::fetchStateT        entryNext,
    output logic                        entryOwns
);

    import fetchPkg::*;

    assign entryOwns = (fetchState == START_OP);

    always_comb begin
        if (!opStart) begin
            entryNext = START_OP; // Idle.
        end else if (opClass == OP_BRANCH) begin
            entryNext = INIT_EXEC_WB; // No operand address needed.
        end else begin
            case (adrMode)
                MODE_DISPL: begin
                    entryNext = FETCH_DISPL;
                end
                MODE_INDEX: begin
                    entryNext = FETCH_EXWORD_1;
                end
                MODE_ABS: begin
                    if (adrReg == ABS_WORD_REG) begin
                        entryNext = FETCH_ABS_LO; // Short absolute.
                    end else begin
                        entryNext = FETCH_ABS_HI;
                    end
                end
                MODE_INDIRECT, MODE_POSTINC, MODE_PREDEC: begin
                    entryNext = CALC_AEFF;
                end
                default: begin // Register direct and the rest.
                    entryNext = INIT_EXEC_WB;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fetchPkg.sv
// Fetch-state sequencer shared definitions.
// State, operation-class and displacement-size encodings, plus the
// brief and full extension-word formats.
`default_nettype none

package fetchPkg;

    localparam int STATE_WIDTH    = 5;
    localparam int ADR_MODE_WIDTH = 3;
    localparam int EXT_WORD_WIDTH = 16;

    typedef enum logic [STATE_WIDTH-1:0] {
        START_OP,
        CALC_AEFF,
        FETCH_DISPL,
        FETCH_EXWORD_1,
        FETCH_D_LO,
        FETCH_D_HI,
        FETCH_OD_HI,
        FETCH_OD_LO,
        FETCH_ABS_HI,
        FETCH_ABS_LO,
        FETCH_MEMADR,
        FETCH_OPERAND,
        INIT_EXEC_WB,
        SLEEP,
        SWITCH_STATE
    } fetchStateT;

    typedef enum logic [2:0] {
        OP_ALU_EA,     // ALU op, effective address source.
        OP_ALU_ADDR,   // ALU op, An destination.
        OP_LOAD_ADR,   // LEA and PEA style.
        OP_CONTROL_EA, // JMP, JSR, Scc and friends.
        OP_BRANCH
    } opClassT;

    // Base and outer displacement size codes.
    typedef enum logic [1:0] {
        SIZE_RESERVED = 2'b00,
        SIZE_NULL     = 2'b01,
        SIZE_WORD     = 2'b10,
        SIZE_LONG     = 2'b11
    } dispSizeT;

    typedef struct packed {
        logic                          idxIsAddr; // Index is An, else Dn.
        logic [2:0]                    idxReg;
        logic                          idxLong;
        logic [1:0]                    scale;
        logic                          fullFormat;
        logic [EXT_WORD_WIDTH/2-1:0]   disp8;
    } briefExtT;

    typedef struct packed {
        logic       idxIsAddr;
        logic [2:0] idxReg;
        logic       idxLong;
        logic [1:0] scale;
        logic       fullFormat;
        logic       baseSuppress;
        logic       indexSuppress;
        dispSizeT   bdSize;
        logic       zeroBit;
        logic [2:0] idxIndSel;      // Low two bits give the outer size.
    } fullExtT;

    typedef union packed {
        briefExtT brief;
        fullExtT  full;
    } extWordT;

    // Effective address modes.
    localparam logic [ADR_MODE_WIDTH-1:0] MODE_INDIRECT = 3'b010;
    localparam logic [ADR_MODE_WIDTH-1:0] MODE_POSTINC  = 3'b011;
    localparam logic [ADR_MODE_WIDTH-1:0] MODE_PREDEC   = 3'b100;
    localparam logic [ADR_MODE_WIDTH-1:0] MODE_DISPL    = 3'b101;
    localparam logic [ADR_MODE_WIDTH-1:0] MODE_INDEX    = 3'b110;
    localparam logic [ADR_MODE_WIDTH-1:0] MODE_ABS      = 3'b111;

    // Register field under MODE_ABS.
    localparam logic [ADR_MODE_WIDTH-1:0] ABS_WORD_REG  = 3'b000;
    localparam logic [ADR_MODE_WIDTH-1:0] ABS_LONG_REG  = 3'b001;

endpackage

`default_nettype wire

//--- fetchSequencer.sv
// Fetch-state sequencer top level.
// Holds the state register and the latched operation class, and picks
// the next state from whichever decoder owns the current state.
`timescale 1ns/1ps
`default_nettype none

module fetchSequencer #(
    parameter int modeWidth = fetchPkg::ADR_MODE_WIDTH
) (
    input  wire                         CLK,
    input  wire                         reset,
    input  wire                         opStart,
    input  wire fetchPkg::opClassT      opClass,
    input  wire [modeWidth-1:0]         adrMode,
    input  wire [modeWidth-1:0]         adrReg,
    input  wire fetchPkg::extWordT      extWord,
    input  wire                         ewAck,
    input  wire                         rdRdy,
    input  wire                         memAdrRdy,
    input  wire                         arInUse,
    input  wire                         drInUse,
    input  wire                         aluBusy,
    input  wire                         execWbIdle,
    output fetchPkg::fetchStateT        fetchState
);

    import fetchPkg::*;

    opClassT    opClassQ;   // Class of the running operation.
    fetchStateT nextState;
    fetchStateT entryNext;
    fetchStateT extNext;
    fetchStateT stepNext;
    logic       entryOwns;
    logic       extOwns;
    logic       stepOwns;
    logic       opAccept;

    assign opAccept = (fetchState == START_OP) && opStart;

    always_ff @(posedge CLK) begin
        if (reset) begin
            fetchState <= START_OP;
            opClassQ   <= OP_ALU_EA;
        end else begin
            fetchState <= nextState;
            if (opAccept) begin
                opClassQ <= opClass;
            end
        end
    end

    always_comb begin
        if (entryOwns) begin
            nextState = entryNext;
        end else if (extOwns) begin
            nextState = extNext;
        end else if (stepOwns) begin
            nextState = stepNext;
        end else begin
            nextState = START_OP; // Unowned code, recover.
        end
    end

    fetchEntryDecoder #(
        .modeWidth (modeWidth)
    ) entryDec (
        .fetchState (fetchState),
        .opStart    (opStart),
        .opClass    (opClass),
        .adrMode    (adrMode),
        .adrReg     (adrReg),
        .entryNext  (entryNext),
        .entryOwns  (entryOwns)
    );

    extWordDecoder extDec (
        .CLK        (CLK),
        .reset      (reset),
        .fetchState (fetchState),
        .opClass    (opClassQ),
        .extWord    (extWord),
        .ewAck      (ewAck),
        .memAdrRdy  (memAdrRdy),
        .arInUse    (arInUse),
        .drInUse    (drInUse),
        .extNext    (extNext),
        .extOwns    (extOwns)
    );

    operandStepDecoder stepDec (
        .fetchState (fetchState),
        .opClass    (opClassQ),
        .rdRdy      (rdRdy),
        .arInUse    (arInUse),
        .drInUse    (drInUse),
        .aluBusy    (aluBusy),
        .execWbIdle (execWbIdle),
        .stepNext   (stepNext),
        .stepOwns   (stepOwns)
    );

endmodule

`default_nettype wire

//--- fetchSequencerTb.sv
// Testbench for the fetch-state sequencer.
// Table rows give the operation, a stall and the expected state path.
// Each row is started with opStart and the state is compared every cycle.
`timescale 1ns/1ps
`default_nettype none

module fetchSequencerTb;

    import fetchPkg::*;

    localparam int clkPeriod = 20;
    localparam int maxRows   = 16;
    localparam int maxPath   = 8;

    localparam logic [3:0] noFlags = 4'b0000;
    localparam logic [3:0] fHold   = 4'b0001; // Stall holds the state.
    localparam logic [3:0] fLead   = 4'b0010; // Stall already high one state earlier.
    localparam logic [3:0] fRand   = 4'b0100; // Length drawn at random.
    localparam logic [3:0] fExtra  = 4'b1000; // Stray opStart mid-operation.

    typedef enum {STALL_NONE, STALL_AR, STALL_DR, STALL_ALU, STALL_WBIDLE} stallT;

    logic                      CLK;
    logic                      reset;
    logic                      opStart;
    opClassT                   opClass;
    logic [ADR_MODE_WIDTH-1:0] adrMode;
    logic [ADR_MODE_WIDTH-1:0] adrReg;
    extWordT                   extWord;
    logic                      ewAck;
    logic                      rdRdy;
    logic                      memAdrRdy;
    logic                      arInUse;
    logic                      drInUse;
    logic                      aluBusy;
    logic                      execWbIdle;
    fetchStateT                fetchState;

    opClassT                   rowClass     [maxRows];
    logic [ADR_MODE_WIDTH-1:0] rowMode      [maxRows];
    logic [ADR_MODE_WIDTH-1:0] rowReg       [maxRows];
    extWordT                   rowExt       [maxRows];
    stallT                     rowStall     [maxRows];
    fetchStateT                rowStallAt   [maxRows];
    int                        rowStallLen  [maxRows];
    int                        rowHoldLen   [maxRows];
    logic [3:0]                rowFlags     [maxRows];
    fetchStateT                rowPath      [maxRows][maxPath];
    int                        rowPathLen   [maxRows];

    int   rowCount    = 0;
    int   curRow      = -1;
    int   errorCount  = 0;
    int   checkCount  = 0;
    int   limitCycles = 0;
    int   seed;
    logic tableReady  = 1'b0;

    tbClockGen #(
        .periodNs    (clkPeriod),
        .resetCycles (4)
    ) clockGen (
        .CLK   (CLK),
        .reset (reset)
    );

    fetchSequencer #(
        .modeWidth (ADR_MODE_WIDTH)
    ) DUT (
        .CLK        (CLK),
        .reset      (reset),
        .opStart    (opStart),
        .opClass    (opClass),
        .adrMode    (adrMode),
        .adrReg     (adrReg),
        .extWord    (extWord),
        .ewAck      (ewAck),
        .rdRdy      (rdRdy),
        .memAdrRdy  (memAdrRdy),
        .arInUse    (arInUse),
        .drInUse    (drInUse),
        .aluBusy    (aluBusy),
        .execWbIdle (execWbIdle),
        .fetchState (fetchState)
    );

    bind fetchSequencer fetchSequencer_assertions stateProps (
        .CLK        (CLK),
        .reset      (reset),
        .fetchState (fetchState)
    );

    task automatic addRow(input opClassT cls, input logic [2:0] mode, input logic [2:0] regField,
                          input logic [15:0] ext, input stallT stall, input fetchStateT stallAt,
                          input int len, input logic [3:0] flags,
                          input fetchStateT s0, s1, s2, s3, s4, s5, s6, s7);
        int k;
        rowClass[rowCount]    = cls;
        rowMode[rowCount]     = mode;
        rowReg[rowCount]      = regField;
        rowExt[rowCount]      = ext;
        rowStall[rowCount]    = stall;
        rowStallAt[rowCount]  = stallAt;
        rowStallLen[rowCount] = len;
        rowFlags[rowCount]    = flags;
        rowPath[rowCount]     = '{s0, s1, s2, s3, s4, s5, s6, s7};
        rowPathLen[rowCount]  = maxPath;
        for (k = maxPath - 1; k >= 0; k--) begin
            if (rowPath[rowCount][k] == START_OP) begin
                rowPathLen[rowCount] = k + 1; // Path ends at the first START_OP.
            end
        end
        rowCount++;
    endtask

    task automatic checkState(input fetchStateT expected);
        checkCount++;
        if (fetchState !== expected) begin
            errorCount++;
            $display("FAIL t=%0t row %0d fetchState expected %s got %s (%0d)", $time, curRow,
                     expected.name(), fetchState.name(), fetchState);
        end
    endtask

    task automatic runRow(input int r);
        fetchStateT expQ[$];
        int         firstIdx;
        int         k;
        int         h;
        int         i;
        logic       lead;
        logic       active;
        firstIdx = -10;
        lead     = (rowFlags[r] & fLead) != 0;
        for (k = 0; k < rowPathLen[r]; k++) begin
            expQ.push_back(rowPath[r][k]);
            if (rowPath[r][k] == rowStallAt[r] && firstIdx < 0) begin
                firstIdx = expQ.size() - 1;
                for (h = 0; h < rowHoldLen[r]; h++) begin
                    expQ.push_back(rowPath[r][k]); // Held while stalled.
                end
            end
        end
        curRow = r;
        @(posedge CLK);
        opStart    <= 1'b1;
        opClass    <= rowClass[r];
        adrMode    <= rowMode[r];
        adrReg     <= rowReg[r];
        extWord    <= rowExt[r];
        arInUse    <= 1'b0;
        drInUse    <= 1'b0;
        aluBusy    <= 1'b0;
        execWbIdle <= 1'b1;
        for (i = 0; i < expQ.size(); i++) begin
            @(posedge CLK);
            active = ((i >= firstIdx) && (i < firstIdx + rowStallLen[r]))
                     || (lead && (i == firstIdx - 1));
            opStart    <= ((rowFlags[r] & fExtra) != 0) && (i == 1);
            arInUse    <= active && (rowStall[r] == STALL_AR);
            drInUse    <= active && (rowStall[r] == STALL_DR);
            aluBusy    <= active && (rowStall[r] == STALL_ALU);
            execWbIdle <= !(active && (rowStall[r] == STALL_WBIDLE));
            @(negedge CLK);
            checkState(expQ[i]);
        end
    endtask

    task automatic loadTable();
        addRow(OP_BRANCH, MODE_DISPL, 3'd0, 16'h0000, STALL_WBIDLE, SLEEP, 3, fHold,
               INIT_EXEC_WB, SLEEP, START_OP, START_OP, START_OP, START_OP, START_OP, START_OP);
        addRow(OP_ALU_EA, MODE_ABS, ABS_WORD_REG, 16'h0000, STALL_NONE, START_OP, 0, noFlags,
               FETCH_ABS_LO, CALC_AEFF, FETCH_OPERAND, INIT_EXEC_WB, START_OP,
               START_OP, START_OP, START_OP);
        addRow(OP_ALU_EA, MODE_ABS, ABS_LONG_REG, 16'h0000, STALL_NONE, START_OP, 0, noFlags,
               FETCH_ABS_HI, FETCH_ABS_LO, CALC_AEFF, FETCH_OPERAND, INIT_EXEC_WB, START_OP,
               START_OP, START_OP);
        addRow(OP_LOAD_ADR, MODE_ABS, ABS_LONG_REG, 16'h0000, STALL_NONE, START_OP, 0, noFlags,
               FETCH_ABS_HI, FETCH_ABS_LO, SWITCH_STATE, INIT_EXEC_WB, START_OP,
               START_OP, START_OP, START_OP);
        // Full format, long base and word outer.
        addRow(OP_CONTROL_EA, MODE_INDEX, 3'd0, 16'h0132, STALL_NONE, START_OP, 0, noFlags,
               FETCH_EXWORD_1, FETCH_D_HI, FETCH_D_LO, FETCH_OD_LO, FETCH_MEMADR, INIT_EXEC_WB,
               START_OP, START_OP);
        addRow(OP_CONTROL_EA, MODE_INDEX, 3'd0, 16'h0133, STALL_NONE, START_OP, 0, noFlags,
               FETCH_EXWORD_1, FETCH_D_HI, FETCH_D_LO, FETCH_OD_HI, FETCH_OD_LO, FETCH_MEMADR,
               INIT_EXEC_WB, START_OP);
        // Null base, null outer, memory indirect.
        addRow(OP_ALU_EA, MODE_INDEX, 3'd0, 16'h0111, STALL_NONE, START_OP, 0, noFlags,
               FETCH_EXWORD_1, FETCH_MEMADR, CALC_AEFF, FETCH_OPERAND, INIT_EXEC_WB, START_OP,
               START_OP, START_OP);
        addRow(OP_ALU_EA, MODE_INDEX, 3'd0, 16'h0100, STALL_NONE, START_OP, 0, noFlags,
               FETCH_EXWORD_1, START_OP, START_OP, START_OP, START_OP, START_OP,
               START_OP, START_OP);
        addRow(OP_ALU_ADDR, MODE_INDEX, 3'd0, 16'h0110, STALL_NONE, START_OP, 0, noFlags,
               FETCH_EXWORD_1, CALC_AEFF, FETCH_OPERAND, INIT_EXEC_WB, START_OP,
               START_OP, START_OP, START_OP);
        addRow(OP_ALU_EA, MODE_DISPL, 3'd2, 16'h0000, STALL_AR, FETCH_DISPL, 0, fHold | fRand,
               FETCH_DISPL, CALC_AEFF, FETCH_OPERAND, INIT_EXEC_WB, START_OP,
               START_OP, START_OP, START_OP);
        // Brief word, D3 index.
        addRow(OP_ALU_EA, MODE_INDEX, 3'd0, 16'h3012, STALL_DR, FETCH_EXWORD_1, 0, fHold | fRand,
               FETCH_EXWORD_1, CALC_AEFF, FETCH_OPERAND, INIT_EXEC_WB, START_OP,
               START_OP, START_OP, START_OP);
        // Brief word, A0 index ignores drInUse.
        addRow(OP_ALU_ADDR, MODE_INDEX, 3'd0, 16'h8012, STALL_DR, FETCH_EXWORD_1, 3, noFlags,
               FETCH_EXWORD_1, CALC_AEFF, FETCH_OPERAND, INIT_EXEC_WB, START_OP,
               START_OP, START_OP, START_OP);
        addRow(OP_ALU_EA, MODE_INDIRECT, 3'd1, 16'h0000, STALL_DR, SWITCH_STATE, 0,
               fHold | fRand | fLead,
               CALC_AEFF, FETCH_OPERAND, SWITCH_STATE, INIT_EXEC_WB, START_OP,
               START_OP, START_OP, START_OP);
        addRow(OP_ALU_ADDR, MODE_POSTINC, 3'd4, 16'h0000, STALL_ALU, INIT_EXEC_WB, 0,
               fHold | fRand | fExtra,
               CALC_AEFF, FETCH_OPERAND, INIT_EXEC_WB, START_OP, START_OP,
               START_OP, START_OP, START_OP);
        // Data register direct needs no fetch.
        addRow(OP_ALU_EA, 3'b000, 3'd5, 16'h0000, STALL_NONE, START_OP, 0, noFlags,
               INIT_EXEC_WB, START_OP, START_OP, START_OP, START_OP, START_OP,
               START_OP, START_OP);
    endtask

    initial begin : mainSeq
        int r;
        opStart    <= 1'b0;
        opClass    <= OP_ALU_EA;
        adrMode    <= '0;
        adrReg     <= '0;
        extWord    <= '0;
        ewAck      <= 1'b1;
        rdRdy      <= 1'b1;
        memAdrRdy  <= 1'b1;
        arInUse    <= 1'b0;
        drInUse    <= 1'b0;
        aluBusy    <= 1'b0;
        execWbIdle <= 1'b1;
        seed        = 32'hf6cc;
        loadTable();
        limitCycles = 4 + 4 + 20; // Reset, idle checks, margin.
        for (r = 0; r < rowCount; r++) begin
            if ((rowFlags[r] & fRand) != 0) begin
                rowStallLen[r] = 1 + int'($unsigned($random(seed)) % 4);
            end
            rowHoldLen[r] = ((rowFlags[r] & fHold) != 0) ? rowStallLen[r] : 0;
            limitCycles += rowPathLen[r] + rowHoldLen[r] + 1;
        end
        tableReady = 1'b1;
        @(negedge CLK);
        while (reset) @(negedge CLK);
        checkState(START_OP);
        repeat (3) begin
            @(negedge CLK);
            checkState(START_OP); // No opStart yet.
        end
        for (r = 0; r < rowCount; r++) begin
            runRow(r);
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (tableReady);
        repeat (limitCycles) @(posedge CLK);
        $display("Timeout: no verdict after %0d cycles, checks run: %0d, errors: %0d",
                 limitCycles, checkCount, errorCount);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetchSequencer_assertions.sv
// Concurrent property checks for the fetch-state sequencer.
// Bound to the top level, watches only the state register.
`timescale 1ns/1ps
`default_nettype none

module fetchSequencer_assertions (
    input wire                       CLK,
    input wire                       reset,
    input wire fetchPkg::fetchStateT fetchState
);

    import fetchPkg::*;

    stateDefined: assert property (@(posedge CLK)
        !reset |-> fetchState inside {START_OP, CALC_AEFF, FETCH_DISPL, FETCH_EXWORD_1,
                                      FETCH_D_LO, FETCH_D_HI, FETCH_OD_HI, FETCH_OD_LO,
                                      FETCH_ABS_HI, FETCH_ABS_LO, FETCH_MEMADR,
                                      FETCH_OPERAND, INIT_EXEC_WB, SLEEP, SWITCH_STATE})
        else $error("fetchState holds an undefined encoding");

    // First sample after reset release.
    idleAfterReset: assert property (@(posedge CLK)
        $fell(reset) |-> fetchState == START_OP)
        else $error("fetchState not idle right after reset");

    calcToOperand: assert property (@(posedge CLK) disable iff (reset)
        fetchState == CALC_AEFF |=> fetchState == FETCH_OPERAND)
        else $error("CALC_AEFF not followed by FETCH_OPERAND");

endmodule

`default_nettype wire

//--- operandStepDecoder.sv
// Operand-step decoder for the fetch sequencer.
// Next state for address calculation, operand read, the switch cycle,
// the execute/writeback hand-off and the sleep wait.
`timescale 1ns/1ps
`default_nettype none

module operandStepDecoder (
    input  wire fetchPkg::fetchStateT   fetchState,
    input  wire fetchPkg::opClassT      opClass,
    input  wire                         rdRdy,
    input  wire                         arInUse,
    input  wire                         drInUse,
    input  wire                         aluBusy,
    input  wire                         execWbIdle,
    output fetchPkg::fetchStateT        stepNext,
    output logic                        stepOwns
);

    import fetchPkg::*;

    always_comb begin
        stepOwns = 1'b1;
        stepNext = fetchState;
        case (fetchState)
            CALC_AEFF: begin
                stepNext = FETCH_OPERAND; // One cycle for the adder.
            end
            FETCH_OPERAND: begin
                if (rdRdy) begin
                    if (opClass == OP_ALU_EA && drInUse) begin
                        stepNext = SWITCH_STATE; // Destination Dn still busy.
                    end else begin
                        stepNext = INIT_EXEC_WB;
                    end
                end
            end
            SWITCH_STATE: begin
                case (opClass)
                    OP_LOAD_ADR: begin
                        stepNext = INIT_EXEC_WB; // Address settles here.
                    end
                    OP_ALU_ADDR: begin
                        if (!arInUse) begin
                            stepNext = INIT_EXEC_WB;
                        end
                    end
                    default: begin
                        if (!drInUse) begin
                            stepNext = INIT_EXEC_WB;
                        end
                    end
                endcase
            end
            INIT_EXEC_WB: begin
                if (!aluBusy) begin
                    if (opClass == OP_BRANCH) begin
                        stepNext = SLEEP; // Let the new flow settle.
                    end else begin
                        stepNext = START_OP;
                    end
                end
            end
            SLEEP: begin
                if (execWbIdle) begin
                    stepNext = START_OP;
                end
            end
            default: begin
                stepOwns = 1'b0;
                stepNext = START_OP;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the fetch sequencer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f src.f \
    --top-module fetchSequencerTb -Mdir obj_dir -o simFetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simFetch)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1

//--- src.f
fetchPkg.sv
fetchEntryDecoder.sv
extWordDecoder.sv
operandStepDecoder.sv
fetchSequencer.sv
tbClockGen.sv
fetchSequencer_assertions.sv
fetchSequencerTb.sv

//--- tbClockGen.sv
// Testbench clock and reset source.
// Free-running clock and a synchronous reset held for a set number of cycles.
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 4
) (
    output logic CLK,
    output logic reset
);

    initial begin
        CLK = 1'b0;
        forever #(periodNs / 2) CLK = ~CLK;
    end

    initial begin
        reset <= 1'b1;
        repeat (resetCycles) @(posedge CLK);
        reset <= 1'b0; // Released on a rising edge.
    end

endmodule

`default_nettype wire
